//--- hw/battle_pkg.sv
`default_nettype none

package battle_pkg;

    typedef enum logic [1:0] {
        species_none  = 2'd0,
        species_leaf  = 2'd1,
        species_water = 2'd2,
        species_fire  = 2'd3
    } species_t;

    typedef logic [1:0] damage_t;      // 0 miss .. 3 strongest
    typedef logic [4:0] roll_t;

    // pick vectors are one-hot: bit 0 leaf, bit 1 water, bit 2 fire
    typedef struct packed {
        logic       p1_select;
        logic       p2_select;
        logic [2:0] pick1;
        logic [2:0] pick2;
    } select_cmd_t;

    typedef struct packed {
        logic basic;
        logic special;
    } move_cmd_t;

    typedef struct packed {
        logic    strike;
        damage_t amount;
    } hit_t;

    typedef struct packed {
        logic    valid;
        logic    normal;                // basic move
        damage_t amount;
        logic    effective;             // type advantage on a special
    } outcome_t;

    typedef enum logic [2:0] {
        msg_none               = 3'd0,
        msg_direct_hit         = 3'd1,
        msg_not_very_effective = 3'd2,
        msg_super_effective    = 3'd3,
        msg_critical_hit       = 3'd4,
        msg_miss               = 3'd5
    } msg_t;

    localparam roll_t ROLL_LAST = 5'd28;   // counter runs 0..29
    localparam int HEALTH_W = 4;
    localparam logic [HEALTH_W-1:0] HEALTH_LIMIT = 4'd12;

    // active-low digit patterns, segment g in bit 6
    localparam logic [6:0] SEG_NONE  = 7'b1000000;
    localparam logic [6:0] SEG_LEAF  = 7'b1111001;
    localparam logic [6:0] SEG_WATER = 7'b0100100;
    localparam logic [6:0] SEG_FIRE  = 7'b0110000;

endpackage

`default_nettype wire

//--- hw/move_damage.sv
`timescale 1ns/10ps
`default_nettype none

module move_damage
    import battle_pkg::*;
(
    input  species_t attacker,
    input  species_t defender,
    input  roll_t    roll,
    output damage_t  amount,
    output logic     effective
);

    logic [3:0] digit;
    logic       att_wins;
    logic       def_wins;

    function automatic logic beats(input species_t a, input species_t b);
        return (a == species_leaf  && b == species_water) ||
               (a == species_water && b == species_fire)  ||
               (a == species_fire  && b == species_leaf);
    endfunction

    assign digit    = 4'(roll % 5'd10);             // last decimal digit of the roll
    assign att_wins = beats(attacker, defender);
    assign def_wins = beats(defender, attacker);

    always_comb
    begin
        effective = 1'b0;
        if (att_wins)
        begin
            amount    = 2'd3;
            effective = 1'b1;
        end
        else if (def_wins)
            amount = (digit == 4'd0) ? 2'd0 : 2'd1;
        else if (digit == 4'd7)
            amount = 2'd3;                          // lucky roll, critical
        else if (digit == 4'd0)
            amount = 2'd0;
        else
            amount = 2'd2;
    end

endmodule

`default_nettype wire

//--- hw/health_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module health_tracker
    import battle_pkg::*;
#(
    parameter logic [HEALTH_W-1:0] HEALTH_FULL = 4'd9
)
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                refill,
    input  hit_t                hit,
    output logic [HEALTH_W-1:0] health,
    output logic                knocked_out
);

    logic [HEALTH_W-1:0] level;

    // anything past the limit has wrapped below zero
    assign knocked_out = (level == '0) || (level >= HEALTH_LIMIT);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            level  <= HEALTH_FULL;
            health <= HEALTH_FULL;
        end
        else
        begin
            if (refill)
                level <= HEALTH_FULL;               // new game overrides a hit
            else if (hit.strike)
                level <= level - HEALTH_W'(hit.amount);
            health <= (level <= HEALTH_LIMIT) ? level : '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/message_select.sv
`timescale 1ns/10ps
`default_nettype none

module message_select
    import battle_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  outcome_t outcome,
    input  logic     draw,
    output msg_t     msg
);

    outcome_t last;
    msg_t     code;

    always_comb
    begin
        if (!last.valid)
            code = msg_none;
        else if (last.normal || last.amount == 2'd2)
            code = msg_direct_hit;
        else if (last.amount == 2'd1)
            code = msg_not_very_effective;
        else if (last.amount == 2'd3)
            code = last.effective ? msg_super_effective : msg_critical_hit;
        else
            code = msg_miss;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            last.valid <= 1'b0;
            msg        <= msg_none;
        end
        else
        begin
            if (outcome.valid)
                last <= outcome;
            msg <= draw ? code : msg_none;
        end
    end

endmodule

`default_nettype wire

//--- hw/species_seg7.sv
`timescale 1ns/10ps
`default_nettype none

module species_seg7
    import battle_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  species_t   species,
    output logic [6:0] seg
);

    always_ff @(posedge clk)
    begin
        if (!resetn)
            seg <= SEG_NONE;
        else
            case (species)
                species_leaf:  seg <= SEG_LEAF;     // digit 1
                species_water: seg <= SEG_WATER;
                species_fire:  seg <= SEG_FIRE;
                default:       seg <= SEG_NONE;
            endcase
    end

endmodule

`default_nettype wire

//--- hw/battle_control.sv
`timescale 1ns/10ps
`default_nettype none

module battle_control
    import battle_pkg::*;
#(
    parameter damage_t BASIC_DAMAGE = 2'd2
)
(
    input  logic        clk,
    input  logic        resetn,
    input  select_cmd_t sel,
    input  move_cmd_t   move1,
    input  move_cmd_t   move2,
    input  damage_t     dmg1,
    input  damage_t     dmg2,
    input  logic        eff1,
    input  logic        eff2,
    input  logic        ko1,
    input  logic        ko2,
    output species_t    species1,
    output species_t    species2,
    output roll_t       roll,
    output hit_t        hit1,
    output hit_t        hit2,
    output logic        refill,
    output outcome_t    out1,
    output outcome_t    out2,
    output logic        p1_win,
    output logic        p2_win
);

    function automatic species_t decode_pick(input logic [2:0] pick, input species_t cur);
        species_t res;
        res = cur;                                  // no pick bit keeps the old choice
        if (pick[0])
            res = species_leaf;
        else if (pick[1])
            res = species_water;
        else if (pick[2])
            res = species_fire;
        return res;
    endfunction

    assign refill = sel.p1_select;

    // special wins over basic when both are set
    always_comb
    begin
        hit1.strike    = move1.basic | move1.special;
        hit1.amount    = move1.special ? dmg1 : BASIC_DAMAGE;
        out1.valid     = hit1.strike;
        out1.normal    = !move1.special;
        out1.amount    = hit1.amount;
        out1.effective = move1.special & eff1;

        hit2.strike    = move2.basic | move2.special;
        hit2.amount    = move2.special ? dmg2 : BASIC_DAMAGE;
        out2.valid     = hit2.strike;
        out2.normal    = !move2.special;
        out2.amount    = hit2.amount;
        out2.effective = move2.special & eff2;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            species1 <= species_none;
            species2 <= species_none;
            roll     <= '0;
            p1_win   <= 1'b0;
            p2_win   <= 1'b0;
        end
        else
        begin
            if (sel.p1_select)
                species1 <= decode_pick(sel.pick1, species1);
            if (sel.p2_select)
                species2 <= decode_pick(sel.pick2, species2);
            if (move1.special || move2.special)
                roll <= (roll > ROLL_LAST) ? '0 : roll + 5'd1;
            p1_win <= ko2;                          // player 2 down takes precedence
            p2_win <= !ko2 && ko1;
        end
    end

endmodule

`default_nettype wire

//--- hw/battle_top.sv
`timescale 1ns/10ps
`default_nettype none

module battle_top
    import battle_pkg::*;
#(
    parameter logic [HEALTH_W-1:0] HEALTH_FULL = 4'd9,
    parameter damage_t BASIC_DAMAGE = 2'd2
)
(
    input  logic                clk,
    input  logic                resetn,
    input  select_cmd_t         sel,
    input  move_cmd_t           move1,
    input  move_cmd_t           move2,
    input  logic                draw_msg1,
    input  logic                draw_msg2,
    output logic [HEALTH_W-1:0] health1,
    output logic [HEALTH_W-1:0] health2,
    output logic                p1_win,
    output logic                p2_win,
    output logic [6:0]          seg1,
    output logic [6:0]          seg2,
    output msg_t                msg1,
    output msg_t                msg2
);

    species_t species1, species2;
    roll_t    roll;
    damage_t  dmg1, dmg2;
    logic     eff1, eff2;
    logic     ko1, ko2;
    logic     refill;
    hit_t     hit1, hit2;
    outcome_t out1, out2;

    battle_control #(.BASIC_DAMAGE(BASIC_DAMAGE)) control0 (
        .clk(clk), .resetn(resetn),
        .sel(sel), .move1(move1), .move2(move2),
        .dmg1(dmg1), .dmg2(dmg2), .eff1(eff1), .eff2(eff2),
        .ko1(ko1), .ko2(ko2),
        .species1(species1), .species2(species2), .roll(roll),
        .hit1(hit1), .hit2(hit2), .refill(refill),
        .out1(out1), .out2(out2),
        .p1_win(p1_win), .p2_win(p2_win)
    );

    // same rule, species order swapped for each attacker
    move_damage damage1 (.attacker(species1), .defender(species2), .roll(roll),
                         .amount(dmg1), .effective(eff1));
    move_damage damage2 (.attacker(species2), .defender(species1), .roll(roll),
                         .amount(dmg2), .effective(eff2));

    health_tracker #(.HEALTH_FULL(HEALTH_FULL)) tracker1 (
        .clk(clk), .resetn(resetn), .refill(refill), .hit(hit2),
        .health(health1), .knocked_out(ko1)
    );
    health_tracker #(.HEALTH_FULL(HEALTH_FULL)) tracker2 (
        .clk(clk), .resetn(resetn), .refill(refill), .hit(hit1),
        .health(health2), .knocked_out(ko2)
    );

    message_select message1 (.clk(clk), .resetn(resetn), .outcome(out1),
                             .draw(draw_msg1), .msg(msg1));
    message_select message2 (.clk(clk), .resetn(resetn), .outcome(out2),
                             .draw(draw_msg2), .msg(msg2));

    species_seg7 digit1 (.clk(clk), .resetn(resetn), .species(species1), .seg(seg1));
    species_seg7 digit2 (.clk(clk), .resetn(resetn), .species(species2), .seg(seg2));

endmodule

`default_nettype wire

//--- tests/battle_sva.sv
`timescale 1ns/10ps
`default_nettype none

module battle_sva
    import battle_pkg::*;
#(
    parameter logic [HEALTH_W-1:0] HEALTH_FULL = 4'd9
)
(
    input logic                clk,
    input logic                resetn,
    input select_cmd_t         sel,
    input logic                draw_msg1,
    input logic                p1_win,
    input logic                p2_win,
    input msg_t                msg1,
    input logic [HEALTH_W-1:0] health1,
    input logic [HEALTH_W-1:0] health2
);

    one_winner: assert property (@(posedge clk) disable iff (!resetn) !(p1_win && p2_win))
        else $error("both win flags high");

    msg_clears: assert property (@(posedge clk) disable iff (!resetn)
        !draw_msg1 |=> msg1 == msg_none)
        else $error("msg1 not none after draw dropped");

    refill_full: assert property (@(posedge clk) disable iff (!resetn)
        sel.p1_select |=> ##1 (health1 == HEALTH_FULL && health2 == HEALTH_FULL))
        else $error("health not full two cycles after p1_select");

endmodule

bind battle_top battle_sva #(.HEALTH_FULL(HEALTH_FULL)) sva0 (
    .clk(clk), .resetn(resetn), .sel(sel), .draw_msg1(draw_msg1),
    .p1_win(p1_win), .p2_win(p2_win), .msg1(msg1),
    .health1(health1), .health2(health2)
);

`default_nettype wire

//--- tests/battle_tb.sv
`timescale 1ns/10ps
`default_nettype none

module battle_tb
    import battle_pkg::*;
;

    localparam logic [3:0] FULL = 4'd9;
    localparam damage_t BASIC = 2'd2;
    localparam int CYCLE_LIMIT = 2000;             // ~150 strobes of up to 3 cycles, with margin

    logic        clk = 1'b0;
    logic        resetn;
    select_cmd_t sel;
    move_cmd_t   move1, move2;
    logic        draw_msg1, draw_msg2;
    logic [3:0]  health1, health2;
    logic        p1_win, p2_win;
    logic [6:0]  seg1, seg2;
    msg_t        msg1, msg2;

    species_t    sp1 = species_none;               // reference model state
    species_t    sp2 = species_none;
    int          roll_m = 0;
    logic [3:0]  hp1 = FULL;
    logic [3:0]  hp2 = FULL;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] rng = 32'hbfd8;

    battle_top #(.HEALTH_FULL(FULL), .BASIC_DAMAGE(BASIC)) dut0 (
        .clk(clk), .resetn(resetn), .sel(sel), .move1(move1), .move2(move2),
        .draw_msg1(draw_msg1), .draw_msg2(draw_msg2),
        .health1(health1), .health2(health2), .p1_win(p1_win), .p2_win(p2_win),
        .seg1(seg1), .seg2(seg2), .msg1(msg1), .msg2(msg2)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("error: timeout after %0d cycles, the tests did not finish", cycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic has_advantage(input species_t a, input species_t b);
        return (a == species_leaf && b == species_water) ||
               (a == species_water && b == species_fire) ||
               (a == species_fire && b == species_leaf);
    endfunction

    // returns {effective, amount}
    function automatic logic [2:0] expect_damage(input species_t att, input species_t def,
                                                 input int r);
        int d;
        d = r % 10;
        if (has_advantage(att, def))
            return 3'b111;
        if (has_advantage(def, att))
            return (d == 0) ? 3'd0 : 3'd1;
        if (d == 7)
            return 3'd3;
        return (d == 0) ? 3'd0 : 3'd2;
    endfunction

    function automatic msg_t expect_msg(input logic normal, input damage_t amt, input logic eff);
        if (normal || amt == 2'd2)
            return msg_direct_hit;
        if (amt == 2'd1)
            return msg_not_very_effective;
        if (amt == 2'd3)
            return eff ? msg_super_effective : msg_critical_hit;
        return msg_miss;
    endfunction

    function automatic species_t pick_species(input logic [2:0] pick, input species_t cur);
        if (pick[0])
            return species_leaf;
        if (pick[1])
            return species_water;
        if (pick[2])
            return species_fire;
        return cur;
    endfunction

    function automatic logic [6:0] seg_of(input species_t s);
        case (s)
            species_leaf:  return SEG_LEAF;
            species_water: return SEG_WATER;
            species_fire:  return SEG_FIRE;
            default:       return SEG_NONE;
        endcase
    endfunction

    function automatic logic ko(input logic [3:0] h);
        return (h == 4'd0) || (h >= HEALTH_LIMIT);
    endfunction

    function automatic logic [3:0] shown(input logic [3:0] h);
        return (h <= HEALTH_LIMIT) ? h : 4'd0;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_state();
        check("health1", 32'(health1), 32'(shown(hp1)));
        check("health2", 32'(health2), 32'(shown(hp2)));
        check("p1_win", 32'(p1_win), 32'(ko(hp2)));
        check("p2_win", 32'(p2_win), 32'(!ko(hp2) && ko(hp1)));
    endtask

    task automatic do_select(input logic p1, input logic p2, input logic [2:0] pick1,
                             input logic [2:0] pick2);
        sel.p1_select = p1;
        sel.p2_select = p2;
        sel.pick1 = pick1;
        sel.pick2 = pick2;
        if (p1)
        begin
            sp1 = pick_species(pick1, sp1);
            hp1 = FULL;                            // p1_select starts a new game
            hp2 = FULL;
        end
        if (p2)
            sp2 = pick_species(pick2, sp2);
        @(negedge clk);
        sel = '0;
        @(negedge clk);
        check("seg1", 32'(seg1), 32'(seg_of(sp1)));
        check("seg2", 32'(seg2), 32'(seg_of(sp2)));
        check_state();
    endtask

    task automatic attack(input int who, input logic basic, input logic special,
                          input logic show);
        logic [2:0] dmg;
        damage_t    amt;
        logic       eff;
        msg_t       exp_msg;
        dmg = (who == 1) ? expect_damage(sp1, sp2, roll_m) : expect_damage(sp2, sp1, roll_m);
        amt = special ? dmg[1:0] : BASIC;
        eff = special & dmg[2];
        exp_msg = expect_msg(!special, amt, eff);
        if (special)
            roll_m = (roll_m == 29) ? 0 : roll_m + 1;
        if (who == 1)
        begin
            move1.basic = basic;
            move1.special = special;
            hp2 = hp2 - 4'(amt);
        end
        else
        begin
            move2.basic = basic;
            move2.special = special;
            hp1 = hp1 - 4'(amt);
        end
        @(negedge clk);
        move1 = '0;
        move2 = '0;
        draw_msg1 = show && (who == 1);
        draw_msg2 = show && (who == 2);
        @(negedge clk);
        check_state();
        check("roll", 32'(dut0.roll), 32'(roll_m));
        check("msg1", 32'(msg1), 32'((show && who == 1) ? exp_msg : msg_none));
        check("msg2", 32'(msg2), 32'((show && who == 2) ? exp_msg : msg_none));
        draw_msg1 = 1'b0;
        draw_msg2 = 1'b0;
        @(negedge clk);
        check("msg1", 32'(msg1), 32'(msg_none));
        check("msg2", 32'(msg2), 32'(msg_none));
    endtask

    task automatic test_reset();
        check("seg1", 32'(seg1), 32'(SEG_NONE));
        check("seg2", 32'(seg2), 32'(SEG_NONE));
        check("msg1", 32'(msg1), 32'(msg_none));
        check("msg2", 32'(msg2), 32'(msg_none));
        check_state();
    endtask

    task automatic test_select();
        logic [2:0] picks [5] = '{3'b001, 3'b010, 3'b100, 3'b110, 3'b000};
        foreach (picks[i])
        begin
            do_select(1'b1, 1'b0, picks[i], 3'b000);
            do_select(1'b0, 1'b1, 3'b000, picks[i]);
            do_select(1'b1, 1'b1, picks[i], picks[4 - i]);
        end
    endtask

    task automatic test_basic();
        do_select(1'b1, 1'b1, 3'b001, 3'b100);
        attack(1, 1'b1, 1'b0, 1'b1);
        attack(2, 1'b1, 1'b0, 1'b1);
        attack(1, 1'b1, 1'b0, 1'b0);               // no draw, message stays none
    endtask

    task automatic test_special();
        for (int a = 0; a < 3; a++)
            for (int d = 0; d < 3; d++)
            begin
                do_select(1'b1, 1'b1, 3'(1 << a), 3'(1 << d));
                repeat (5)
                begin
                    rng = xorshift(rng);
                    attack(rng[0] ? 2 : 1, rng[1], 1'b1, 1'b1);   // basic bit may ride along
                end
            end
    endtask

    task automatic test_knockout();
        do_select(1'b1, 1'b1, 3'b001, 3'b010);
        for (int i = 0; i < 10 && !ko(hp2); i++)
            attack(1, 1'b1, 1'b0, 1'b1);
        check("health2", 32'(health2), 32'(0));
        check("p1_win", 32'(p1_win), 32'(1));
        do_select(1'b1, 1'b0, 3'b001, 3'b000);
        for (int i = 0; i < 10 && !ko(hp1); i++)
            attack(2, 1'b1, 1'b0, 1'b0);
        check("health1", 32'(health1), 32'(0));
        check("p2_win", 32'(p2_win), 32'(1));
        for (int i = 0; i < 10 && !ko(hp2); i++)
            attack(1, 1'b1, 1'b0, 1'b0);           // player 1 wins when both are down
        check("p1_win", 32'(p1_win), 32'(1));
        check("p2_win", 32'(p2_win), 32'(0));
        do_select(1'b1, 1'b0, 3'b000, 3'b000);
    endtask

    initial
    begin
        resetn = 1'b0;
        sel = '0;
        move1 = '0;
        move2 = '0;
        draw_msg1 = 1'b0;
        draw_msg2 = 1'b0;
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        test_reset();
        test_select();
        test_basic();
        test_special();
        test_knockout();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hw/battle_pkg.sv
hw/move_damage.sv
hw/health_tracker.sv
hw/message_select.sv
hw/species_seg7.sv
hw/battle_control.sv
hw/battle_top.sv
tests/battle_sva.sv
tests/battle_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log && rm -rf obj_dir && \
verilator --binary --timing --assert --top-module battle_tb -f build.f && \
./obj_dir/Vbattle_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^sim passed$" sim.log && echo "result: ok" || { echo "result: failure"; exit 1; }
